/* design/uart_pkg.sv */
// register map, field positions and payload types shared by every uart_lite RTL block
package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths and register map
  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;

  localparam logic [ADDR_W-1:0] REG_RB_TR = 3'd0;  // rx buffer / tx holding, dl1 under dlab
  localparam logic [ADDR_W-1:0] REG_IE    = 3'd1;  // int enable, dl2 under dlab
  localparam logic [ADDR_W-1:0] REG_II_FC = 3'd2;  // iir on read, fcr on write
  localparam logic [ADDR_W-1:0] REG_LC    = 3'd3;
  localparam logic [ADDR_W-1:0] REG_MC    = 3'd4;
  localparam logic [ADDR_W-1:0] REG_LS    = 3'd5;
  localparam logic [ADDR_W-1:0] REG_SR    = 3'd7;  // scratch

  //////////////////////////////////////////////////////////////////////
  // baud and fifo sizing
  localparam int DIV_W      = 16;  // divisor latch
  localparam int OVERSAMPLE = 16;  // baud enables per bit
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_CNT_W = 5;   // holds 0..16

  // reset values and iir identification codes
  localparam logic [DATA_W-1:0] LCR_RESET = 8'h03;  // 8n1
  localparam logic [3:0]        IIR_NONE  = 4'b0001;
  localparam logic [2:0]        II_RLS    = 3'd3;   // highest priority
  localparam logic [2:0]        II_RDA    = 3'd2;
  localparam logic [2:0]        II_THRE   = 3'd1;

  // bit positions
  localparam int LC_DLAB = 7;
  localparam int MC_LOOP = 4;
  localparam int IE_RDA  = 0;
  localparam int IE_THRE = 1;
  localparam int IE_RLS  = 2;

  //////////////////////////////////////////////////////////////////////
  // fifo payloads
  typedef logic [DATA_W-1:0] tx_char_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              fe;  // stop bit sampled low
  } rx_char_t;

endpackage

/* design/uart_fifo.sv */
// 16-entry synchronous FIFO, payload set by type parameter, used for tx bytes and rx chars
module uart_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                            clk,
  input  logic                            wb_rst_i,
  input  logic                            clear_i,
  input  logic                            push_i,
  input  logic                            pop_i,
  input  payload_t                        data_i,
  output payload_t                        data_o,
  output logic [uart_pkg::FIFO_CNT_W-1:0] count_o,
  output logic                            full_o
);
  import uart_pkg::*;

  payload_t              mem [FIFO_DEPTH];
  logic [FIFO_CNT_W-2:0] wr_ptr;   // wraps at depth
  logic [FIFO_CNT_W-2:0] rd_ptr;
  logic                  do_push;
  logic                  do_pop;

  assign full_o  = (count_o == FIFO_CNT_W'(FIFO_DEPTH));
  assign do_push = push_i && !full_o;      // push into full fifo is dropped
  assign do_pop  = pop_i && (count_o != '0); // pop from empty ignored
  assign data_o  = mem[rd_ptr];             // head shown combinationally

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else if (clear_i) begin  // fcr reset empties the fifo
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      count_o <= count_o + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

/* design/uart_baud_gen.sv */
// divisor counter that produces the 16x oversampling enable for tx and rx
module uart_baud_gen (
  input  logic                       clk,
  input  logic                       wb_rst_i,
  input  logic [uart_pkg::DIV_W-1:0] dl_i,
  input  logic                       start_i,   // dl1 written, restart count
  output logic                       baud_en_o
);
  import uart_pkg::*;

  logic [DIV_W-1:0] dlc;  // down counter

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      dlc <= '0;
    end else if (start_i || dlc == '0) begin
      dlc <= dl_i - DIV_W'(1);  // period of dl clocks
    end else begin
      dlc <= dlc - DIV_W'(1);
    end
  end

  // one clock pulse per period, silent while divisor is zero
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      baud_en_o <= 1'b0;
    end else begin
      baud_en_o <= (dlc == '0) && (dl_i != '0);
    end
  end

endmodule

/* design/uart_tx.sv */
// transmit path: tx FIFO plus 8N1 serializer, one bit per 16 baud enables
module uart_tx (
  input  logic                            clk,
  input  logic                            wb_rst_i,
  input  logic                            baud_en_i,
  input  logic                            push_i,
  input  uart_pkg::tx_char_t              data_i,
  input  logic                            fifo_reset_i,
  output logic                            serial_o,
  output logic [uart_pkg::FIFO_CNT_W-1:0] count_o,
  output logic                            idle_o
);
  import uart_pkg::*;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef logic [$clog2(OVERSAMPLE)-1:0] tick_t;

  tx_state_t  state;
  tx_char_t   head;     // fifo head
  tx_char_t   shreg;    // lsb goes out next
  tick_t      tick;     // enables within current bit
  logic [2:0] bit_cnt;
  logic       pop;
  logic       bit_end;

  assign idle_o  = (state == TX_IDLE);
  assign pop     = idle_o && (count_o != '0) && baud_en_i;  // start aligned to an enable
  assign bit_end = baud_en_i && (&tick);

  uart_fifo #(.payload_t(tx_char_t)) tx_fifo_i (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .clear_i  (fifo_reset_i),
    .push_i   (push_i),
    .pop_i    (pop),
    .data_i   (data_i),
    .data_o   (head),
    .count_o  (count_o),
    .full_o   ()           // full writes are just dropped
  );

  //////////////////////////////////////////////////////////////////////
  // serializer FSM
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state    <= TX_IDLE;
      serial_o <= 1'b1;  // line idles high
      tick     <= '0;
      bit_cnt  <= '0;
    end else begin
      if (baud_en_i && !idle_o) tick <= tick + 1'b1;
      case (state)
        TX_IDLE: if (pop) begin
          state    <= TX_START;
          serial_o <= 1'b0;  // start bit
          tick     <= '0;
        end
        TX_START: if (bit_end) begin
          state    <= TX_DATA;
          serial_o <= shreg[0];
          bit_cnt  <= '0;
        end
        TX_DATA: if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (&bit_cnt) begin
            state    <= TX_STOP;
            serial_o <= 1'b1;         // stop bit
          end else begin
            serial_o <= shreg[1];     // next bit, before the shift lands
          end
        end
        TX_STOP: if (bit_end) state <= TX_IDLE;
        default: state <= TX_IDLE;
      endcase
    end
  end

  // shift register payload
  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= head;
    end else if (state == TX_DATA && bit_end) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

/* design/uart_rx.sv */
// receive path: input sync, 16x oversampled deserializer, framing check and rx FIFO
module uart_rx (
  input  logic                            clk,
  input  logic                            wb_rst_i,
  input  logic                            baud_en_i,
  input  logic                            serial_i,
  input  logic                            pop_i,
  input  logic                            fifo_reset_i,
  output uart_pkg::rx_char_t              head_o,
  output logic [uart_pkg::FIFO_CNT_W-1:0] count_o,
  output logic                            overrun_o,
  output logic                            push_o     // char received
);
  import uart_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
  typedef logic [$clog2(OVERSAMPLE)-1:0] tick_t;

  rx_state_t         state;
  logic [1:0]        sync;     // metastability flops
  logic              rx_s;
  tick_t             tick;
  logic [2:0]        bit_cnt;
  logic              bit_end;  // sample point, mid-bit
  logic [DATA_W-1:0] shreg;
  logic              fe;
  logic              full;
  rx_char_t          rx_char;

  // two flop sync, preset to idle level
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], serial_i};
    end
  end

  assign rx_s    = sync[1];
  assign bit_end = baud_en_i && (&tick);

  //////////////////////////////////////////////////////////////////////
  // deserializer FSM
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state   <= RX_IDLE;
      tick    <= '0;
      bit_cnt <= '0;
      push_o  <= 1'b0;
    end else begin
      push_o <= 1'b0;
      if (baud_en_i && state != RX_IDLE) tick <= tick + 1'b1;
      case (state)
        // line idles high, so low seen here is the start edge
        RX_IDLE: if (baud_en_i && !rx_s) begin
          state <= RX_START;
          tick  <= tick_t'(OVERSAMPLE / 2);  // wraps after half a bit
        end
        RX_START: if (bit_end) begin
          state   <= rx_s ? RX_IDLE : RX_DATA;  // glitch, back to idle
          bit_cnt <= '0;
        end
        RX_DATA: if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (&bit_cnt) state <= RX_STOP;
        end
        RX_STOP: if (bit_end) begin
          state  <= RX_IDLE;
          push_o <= 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // data and framing flag, lsb first
  always_ff @(posedge clk) begin
    if (bit_end && state == RX_DATA) shreg <= {rx_s, shreg[DATA_W-1:1]};
    if (bit_end && state == RX_STOP) fe <= !rx_s;
  end

  assign rx_char   = '{data: shreg, fe: fe};
  assign overrun_o = push_o && full;  // char lost

  uart_fifo #(.payload_t(rx_char_t)) rx_fifo_i (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .clear_i  (fifo_reset_i),
    .push_i   (push_o),
    .pop_i    (pop_i),
    .data_i   (rx_char),
    .data_o   (head_o),
    .count_o  (count_o),
    .full_o   (full)
  );

endmodule

/* design/uart_regs.sv */
// register file with read mux, LSR/IIR status and interrupt pending logic for the bus side
module uart_regs (
  input  logic                            clk,
  input  logic                            wb_rst_i,
  input  logic [uart_pkg::ADDR_W-1:0]     wb_addr_i,
  input  logic [uart_pkg::DATA_W-1:0]     wb_dat_i,
  output logic [uart_pkg::DATA_W-1:0]     wb_dat_o,
  input  logic                            wb_we_i,
  input  logic                            wb_re_i,
  input  logic [uart_pkg::FIFO_CNT_W-1:0] tf_count_i,
  input  logic                            tx_idle_i,
  input  logic [uart_pkg::FIFO_CNT_W-1:0] rf_count_i,
  input  uart_pkg::rx_char_t              rf_head_i,
  input  logic                            rf_overrun_i,
  input  logic                            rf_push_i,
  output logic                            tf_push_o,
  output uart_pkg::tx_char_t              tf_data_o,
  output logic                            tx_reset_o,
  output logic                            rf_pop_o,
  output logic                            rx_reset_o,
  output logic [uart_pkg::DIV_W-1:0]      dl_o,
  output logic                            start_dlc_o,
  output logic                            loopback_o,
  output logic                            int_o
);
  import uart_pkg::*;

  logic [3:0]        ier;
  logic [DATA_W-1:0] lcr;
  logic [4:0]        mcr;
  logic [DATA_W-1:0] scratch;
  logic [DATA_W-1:0] lsr;
  logic [3:0]        iir;
  logic              dlab, wr_tr, rd_rb, rd_iir, rd_lsr, rd_lsr_d, lsr_clr;
  logic              dr, oe, fe, thre, temt, head_chk;
  logic              rls_pnd, rda_pnd, thre_int, thre_int_d, thre_pnd;

  assign dlab       = lcr[LC_DLAB];
  assign loopback_o = mcr[MC_LOOP];
  assign wr_tr      = wb_we_i && wb_addr_i == REG_RB_TR && !dlab;
  assign rd_rb      = wb_re_i && wb_addr_i == REG_RB_TR && !dlab;
  assign rd_iir     = wb_re_i && wb_addr_i == REG_II_FC;
  assign rd_lsr     = wb_re_i && wb_addr_i == REG_LS;

  //////////////////////////////////////////////////////////////////////
  // writes, strobes show up one clock after the bus access
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ier <= '0; lcr <= LCR_RESET; mcr <= '0; dl_o <= '0;
      tf_push_o   <= 1'b0;
      rf_pop_o    <= 1'b0;
      start_dlc_o <= 1'b0;
      rx_reset_o  <= 1'b0;
      tx_reset_o  <= 1'b0;
    end else begin
      tf_push_o   <= wr_tr;
      rf_pop_o    <= rd_rb;
      start_dlc_o <= wb_we_i && wb_addr_i == REG_RB_TR && dlab;
      rx_reset_o  <= wb_we_i && wb_addr_i == REG_II_FC && wb_dat_i[1];  // fcr bit 1
      tx_reset_o  <= wb_we_i && wb_addr_i == REG_II_FC && wb_dat_i[2];  // fcr bit 2
      if (wb_we_i) begin
        case (wb_addr_i)
          REG_RB_TR: if (dlab) dl_o[DATA_W-1:0] <= wb_dat_i;
          REG_IE: if (dlab) dl_o[DIV_W-1:DATA_W] <= wb_dat_i;
                  else ier <= wb_dat_i[3:0];
          REG_LC: lcr <= wb_dat_i;
          REG_MC: mcr <= wb_dat_i[4:0];
          default: ;
        endcase
      end
    end
  end

  // payload regs
  always_ff @(posedge clk) begin
    if (wr_tr) tf_data_o <= wb_dat_i;
    if (wb_we_i && wb_addr_i == REG_SR) scratch <= wb_dat_i;
  end

  //////////////////////////////////////////////////////////////////////
  // line status
  assign dr      = (rf_count_i != '0);
  assign thre    = (tf_count_i == '0);
  assign temt    = thre && tx_idle_i;  // shifter done too
  assign lsr     = {1'b0, temt, thre, 1'b0, fe, 1'b0, oe, dr};
  assign lsr_clr = rd_lsr && !rd_lsr_d;  // first cycle of lsr read

  // interrupt sources
  assign rls_pnd  = ier[IE_RLS] && (oe || fe);
  assign rda_pnd  = ier[IE_RDA] && dr;
  assign thre_int = ier[IE_THRE] && thre;

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rd_lsr_d <= 1'b0; oe <= 1'b0; fe <= 1'b0; head_chk <= 1'b0;
      thre_int_d <= 1'b0;
      thre_pnd   <= 1'b0;
      int_o      <= 1'b0;
    end else begin
      rd_lsr_d <= rd_lsr;
      head_chk <= rf_pop_o || (rf_push_i && !dr);  // new char reaches head
      oe       <= (oe && !lsr_clr) || rf_overrun_i;
      fe       <= (fe && !lsr_clr) || (head_chk && dr && rf_head_i.fe);
      thre_int_d <= thre_int;
      if (wr_tr || (rd_iir && iir == {II_THRE, 1'b0}) || !ier[IE_THRE]) begin
        thre_pnd <= 1'b0;
      end else if (thre_int && !thre_int_d) begin
        thre_pnd <= 1'b1;  // fifo just went empty
      end
      int_o <= rls_pnd || rda_pnd || thre_pnd;
    end
  end

  // priority rls > rda > thre, bit 0 low when pending
  always_comb begin
    if (rls_pnd)       iir = {II_RLS, 1'b0};
    else if (rda_pnd)  iir = {II_RDA, 1'b0};
    else if (thre_pnd) iir = {II_THRE, 1'b0};
    else               iir = IIR_NONE;
  end

  // read mux, combinational from address
  always_comb begin
    case (wb_addr_i)
      REG_RB_TR: wb_dat_o = dlab ? dl_o[DATA_W-1:0] : rf_head_i.data;
      REG_IE:    wb_dat_o = dlab ? dl_o[DIV_W-1:DATA_W] : {4'b0, ier};
      REG_II_FC: wb_dat_o = 8'hC0 | {4'b0, iir};  // fifos always on
      REG_LC:    wb_dat_o = lcr;
      REG_MC:    wb_dat_o = {3'b0, mcr};
      REG_LS:    wb_dat_o = lsr;
      REG_SR:    wb_dat_o = scratch;
      default:   wb_dat_o = '0;
    endcase
  end

endmodule

/* design/uart_core.sv */
// uart_lite top: register block, baud generator, tx and rx paths plus loopback muxes
module uart_core (
  input  logic                        clk,
  input  logic                        wb_rst_i,
  input  logic [uart_pkg::ADDR_W-1:0] wb_addr_i,
  input  logic [uart_pkg::DATA_W-1:0] wb_dat_i,
  output logic [uart_pkg::DATA_W-1:0] wb_dat_o,
  input  logic                        wb_we_i,
  input  logic                        wb_re_i,
  input  logic                        srx_pad_i,
  output logic                        stx_pad_o,
  output logic                        int_o,
  output logic                        baud_o
);
  import uart_pkg::*;

  logic [FIFO_CNT_W-1:0] tf_count, rf_count;
  logic [DIV_W-1:0]      dl;
  tx_char_t              tf_data;
  rx_char_t              rf_head;
  logic                  tf_push, tx_reset, tx_idle, tx_serial;
  logic                  rf_pop, rx_reset, rf_overrun, rf_push, rx_serial;
  logic                  start_dlc, loopback;

  // loopback, tx folds back into rx, pad held idle
  assign rx_serial = loopback ? tx_serial : srx_pad_i;
  assign stx_pad_o = loopback ? 1'b1 : tx_serial;

  uart_regs regs_i (
    .clk (clk), .wb_rst_i (wb_rst_i),
    .wb_addr_i (wb_addr_i), .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o),
    .wb_we_i (wb_we_i), .wb_re_i (wb_re_i),
    .tf_count_i (tf_count), .tx_idle_i (tx_idle),
    .rf_count_i (rf_count), .rf_head_i (rf_head),
    .rf_overrun_i (rf_overrun), .rf_push_i (rf_push),
    .tf_push_o (tf_push), .tf_data_o (tf_data), .tx_reset_o (tx_reset),
    .rf_pop_o (rf_pop), .rx_reset_o (rx_reset),
    .dl_o (dl), .start_dlc_o (start_dlc), .loopback_o (loopback), .int_o (int_o)
  );

  uart_baud_gen baud_gen_i (
    .clk (clk), .wb_rst_i (wb_rst_i),
    .dl_i (dl), .start_i (start_dlc), .baud_en_o (baud_o)
  );

  uart_tx tx_i (
    .clk (clk), .wb_rst_i (wb_rst_i), .baud_en_i (baud_o),
    .push_i (tf_push), .data_i (tf_data), .fifo_reset_i (tx_reset),
    .serial_o (tx_serial), .count_o (tf_count), .idle_o (tx_idle)
  );

  uart_rx rx_i (
    .clk (clk), .wb_rst_i (wb_rst_i), .baud_en_i (baud_o),
    .serial_i (rx_serial), .pop_i (rf_pop), .fifo_reset_i (rx_reset),
    .head_o (rf_head), .count_o (rf_count),
    .overrun_o (rf_overrun), .push_o (rf_push)
  );

endmodule

/* testbench/tb_clock.sv */
// testbench clock and reset source for uart_lite, 8 unit period, reset held for 5 cycles
module tb_clock (
  output logic clk_o,
  output logic rst_o
);
  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset drops right after the 5th rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* testbench/uart_core_tb.sv */
// self-checking testbench for uart_lite that drives the register bus and both serial lines as top
module uart_core_tb;
  import uart_pkg::*;

  localparam int          DIVISOR        = 2;
  localparam int          BIT_CLKS       = OVERSAMPLE * DIVISOR;  // 32 clocks per bit
  localparam int          TIMEOUT_CYCLES = 20000;                 // ~40 frames plus margin
  localparam logic [31:0] SEED           = 32'h41f30a7d;

  logic              clk, wb_rst_i;
  logic [ADDR_W-1:0] wb_addr_i;
  logic [DATA_W-1:0] wb_dat_i, wb_dat_o;
  logic              wb_we_i, wb_re_i;
  logic              srx_pad_i, stx_pad_o, int_o, baud_o;
  logic              div_set;   // divisor programmed
  logic              loop_on;   // mcr loop bit set
  logic [7:0]        exp_q[$];  // bytes in flight
  logic [7:0]        rd, b;
  int                i;
  int                cycles   = 0;

  tb_clock clock_i (.clk_o (clk), .rst_o (wb_rst_i));

  uart_core uart_core_i (
    .clk (clk), .wb_rst_i (wb_rst_i),
    .wb_addr_i (wb_addr_i), .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o),
    .wb_we_i (wb_we_i), .wb_re_i (wb_re_i),
    .srx_pad_i (srx_pad_i), .stx_pad_o (stx_pad_o), .int_o (int_o), .baud_o (baud_o)
  );

  //////////////////////////////////////////////////////////////////////
  // error reporting and checks
  task automatic fail_now();
    $display("Test failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
    $display("FAILED at %0t: %s expected 8'h%02h, got 8'h%02h", $time, name, exp, got);
    fail_now();
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
    assert (got === exp) else report_mismatch(name, exp, got);
  endtask

  task automatic check_irq(input logic exp);
    @(negedge clk);  // int_o is registered so look mid cycle
    check_value("int_o", {7'b0, exp}, {7'b0, int_o});
  endtask

  // quiet until the divisor is written
  assert property (@(posedge clk) disable iff (wb_rst_i)
                   !div_set |-> (!baud_o && !int_o))
    else report_mismatch("baud_o|int_o", 8'h00, {6'b0, baud_o, int_o});

  // pad stays idle in loopback
  assert property (@(posedge clk) disable iff (wb_rst_i) loop_on |-> stx_pad_o)
    else report_mismatch("stx_pad_o", 8'h01, {7'b0, stx_pad_o});

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_now();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and serial models
  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
    @(posedge clk);
    wb_addr_i <= addr;
    wb_dat_i  <= data;
    wb_we_i   <= 1'b1;
    @(posedge clk);
    wb_we_i   <= 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
    @(posedge clk);
    wb_addr_i <= addr;
    wb_re_i   <= 1'b1;
    @(negedge clk);
    data = wb_dat_o;  // combinational read
    @(posedge clk);
    wb_re_i   <= 1'b0;
  endtask

  task automatic wait_rx_ready();
    logic [7:0] lsr;
    lsr = 8'h00;
    while (!lsr[0]) bus_read(REG_LS, lsr);  // poll DR
  endtask

  task automatic wait_for_irq();
    while (int_o !== 1'b1) @(negedge clk);
  endtask

  // 8N1 frame into srx_pad_i followed by one idle bit
  task automatic send_frame(input logic [7:0] data, input logic stop_bit);
    logic [10:0] frame;
    int          n;
    frame = {1'b1, stop_bit, data, 1'b0};
    for (n = 0; n < 11; n++) begin
      @(posedge clk);
      srx_pad_i <= frame[n];
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
  endtask

  // decodes one frame off stx_pad_o by sampling mid-bit
  task automatic watch_tx_frame(output logic [7:0] data);
    int n;
    while (stx_pad_o !== 1'b0) @(negedge clk);  // start edge
    repeat (BIT_CLKS / 2) @(negedge clk);
    check_value("stx_pad_o start bit", 8'h00, {7'b0, stx_pad_o});
    for (n = 0; n < 8; n++) begin
      repeat (BIT_CLKS) @(negedge clk);
      data[n] = stx_pad_o;  // lsb first
    end
    repeat (BIT_CLKS) @(negedge clk);
    check_value("stx_pad_o stop bit", 8'h01, {7'b0, stx_pad_o});
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    void'($urandom(SEED));
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_re_i   = 1'b0;
    srx_pad_i = 1'b1;  // line idle
    div_set   = 1'b0;
    loop_on   = 1'b0;
    wait (wb_rst_i === 1'b0);
    @(posedge clk);

    // reset values
    bus_read(REG_LC, rd);
    check_value("lcr", 8'h03, rd);
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC1, rd);
    bus_read(REG_LS, rd);
    check_value("lsr", 8'h60, rd);

    // divisor latch, scratch and ier
    bus_write(REG_LC, 8'h83);
    bus_read(REG_LC, rd);
    check_value("lcr", 8'h83, rd);
    bus_write(REG_IE, 8'h5A);
    bus_read(REG_IE, rd);
    check_value("dl2", 8'h5A, rd);
    bus_write(REG_IE, 8'h00);
    bus_write(REG_RB_TR, 8'(DIVISOR));  // restarts the baud counter
    div_set = 1'b1;
    bus_read(REG_RB_TR, rd);
    check_value("dl1", 8'(DIVISOR), rd);
    bus_read(REG_IE, rd);
    check_value("dl2", 8'h00, rd);
    bus_write(REG_LC, LCR_RESET);
    bus_write(REG_SR, 8'hA5);
    bus_read(REG_SR, rd);
    check_value("scratch", 8'hA5, rd);
    bus_write(REG_IE, 8'hF8);  // only bit 3 sticks and it arms no source
    bus_read(REG_IE, rd);
    check_value("ier", 8'h08, rd);
    bus_write(REG_IE, 8'h00);

    // serial tx with writer and line monitor side by side
    fork
      begin
        for (i = 0; i < 3; i++) begin
          b = 8'($urandom());
          exp_q.push_back(b);
          bus_write(REG_RB_TR, b);
        end
      end
      begin
        repeat (3) begin
          watch_tx_frame(rd);
          check_value("stx_pad_o data", exp_q.pop_front(), rd);
        end
      end
    join
    rd = 8'h00;
    while (!rd[6]) bus_read(REG_LS, rd);  // TEMT
    check_value("lsr", 8'h60, rd);

    // loopback
    bus_write(REG_MC, 8'h10);
    loop_on = 1'b1;
    for (i = 0; i < 4; i++) begin
      b = 8'($urandom());
      exp_q.push_back(b);
      bus_write(REG_RB_TR, b);
    end
    for (i = 0; i < 4; i++) begin
      wait_rx_ready();
      bus_read(REG_RB_TR, rd);
      check_value("rb", exp_q.pop_front(), rd);
    end
    bus_read(REG_LS, rd);
    check_value("lsr dr", 8'h00, rd & 8'h01);
    loop_on = 1'b0;
    bus_write(REG_MC, 8'h00);

    // framing error then overrun with only the rls interrupt enabled
    bus_write(REG_IE, 8'h04);
    send_frame(8'($urandom()), 1'b0);
    wait_for_irq();
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC6, rd);
    bus_read(REG_LS, rd);
    check_value("lsr", 8'h69, rd);  // FE and DR
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC1, rd);
    check_irq(1'b0);
    bus_write(REG_II_FC, 8'h02);  // rx fifo reset
    bus_read(REG_LS, rd);
    check_value("lsr", 8'h60, rd);
    for (i = 0; i < 17; i++) begin
      b = 8'($urandom());
      exp_q.push_back(b);
      send_frame(b, 1'b1);
    end
    wait_for_irq();
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC6, rd);
    bus_read(REG_LS, rd);
    check_value("lsr", 8'h63, rd);  // OE and DR
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC1, rd);
    check_irq(1'b0);
    for (i = 0; i < 16; i++) begin
      bus_read(REG_RB_TR, rd);
      check_value("rb", exp_q.pop_front(), rd);
    end
    exp_q.delete();  // 17th was dropped
    bus_read(REG_LS, rd);
    check_value("lsr", 8'h60, rd);

    // priority rda over thre
    bus_write(REG_IE, 8'h03);
    b = 8'($urandom());
    send_frame(b, 1'b1);
    wait_rx_ready();
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC4, rd);
    bus_read(REG_RB_TR, rd);
    check_value("rb", b, rd);
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC2, rd);
    bus_read(REG_II_FC, rd);  // cleared by the read above
    check_value("iir", 8'hC1, rd);
    check_irq(1'b0);
    bus_write(REG_RB_TR, 8'($urandom()));
    while (stx_pad_o !== 1'b0) @(negedge clk);  // byte moved to the shifter
    wait_for_irq();                              // thre raised again
    bus_write(REG_RB_TR, 8'($urandom()));        // waits behind the busy shifter
    bus_read(REG_II_FC, rd);
    check_value("iir", 8'hC1, rd);
    check_irq(1'b0);
    bus_write(REG_IE, 8'h00);

    $display("Test passed");
    $finish;
  end

endmodule

/* uart_lite.f */
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_core.sv
testbench/tb_clock.sv
testbench/uart_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds uart_lite with Verilator, runs the testbench, passes only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module uart_core_tb -f uart_lite.f \
  || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vuart_core_tb)"
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
